// File: verilog/busPkg.sv
`default_nettype none

// widths and sizes seen on the single-word bus and the SRAM target
package busPkg;

    // word address width
    localparam int ADDR_W = 32;

    // data word width, every access is a full word
    localparam int DATA_W = 32;

    // number of words in the on-chip SRAM
    localparam int SRAM_WORDS = 256;

    // index bits needed to reach every SRAM word
    localparam int SRAM_AW = $clog2(SRAM_WORDS);

    // a word address as issued by the CPU
    typedef logic [ADDR_W-1:0] addr_t;

    // a data word
    typedef logic [DATA_W-1:0] data_t;

    // index into the SRAM array
    typedef logic [SRAM_AW-1:0] sramIdx_t;

    // word addresses from 0 to SRAM_WORDS-1 hit the SRAM
    // anything above answers with err
    localparam addr_t SRAM_LAST = addr_t'(SRAM_WORDS - 1);

endpackage

`default_nettype wire

// File: verilog/mmioPkg.sv
`default_nettype none

// request-side definitions for the MMIO bridge and the bus manager
package mmioPkg;

    // two-bit access code from the CPU
    // read = 10, write = 01, idle = 00; 11 falls back to idle
    typedef enum logic [1:0] {
        ACC_IDLE  = 2'b00,
        ACC_WRITE = 2'b01,
        ACC_READ  = 2'b10
    } accessKind_e;

    // requests the FIFO can buffer
    localparam int FIFO_DEPTH = 4;

    // bits for a FIFO slot index
    localparam int FIFO_PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // bits to count credits from 0 up to FIFO_DEPTH inclusive
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    // credit counter and FIFO fill level
    typedef logic [CREDIT_W-1:0] credit_t;

    // slot pointer inside the FIFO
    typedef logic [FIFO_PTR_W-1:0] fifoPtr_t;

    // full count as a credit value, used for reset and limits
    localparam credit_t CREDIT_MAX = credit_t'(FIFO_DEPTH);

    // bus manager states
    // idle grants an issue credit, bus runs the cycle, resp shows the result
    typedef enum logic [1:0] {
        MGR_IDLE = 2'b00,
        MGR_BUS  = 2'b01,
        MGR_RESP = 2'b10
    } mgrState_e;

endpackage

`default_nettype wire

// File: verilog/reqCreditIf.sv
`timescale 1ns/1ps
`default_nettype none

// one request link with credit return
// the sender only raises valid while it holds a credit, there is no ready
interface reqCreditIf
    import busPkg::*;
();

    // one request in this cycle
    logic  valid;
    addr_t addr;
    data_t wdata;
    // 1 for a write, 0 for a read
    logic  write;
    // one-cycle pulse from the receiver, worth one slot
    logic  credit;

    modport sender (
        output valid,
        output addr,
        output wdata,
        output write,
        input  credit
    );

    modport receiver (
        input  valid,
        input  addr,
        input  wdata,
        input  write,
        output credit
    );

endinterface

`default_nettype wire

// File: verilog/mmioRequester.sv
`timescale 1ns/1ps
`default_nettype none

// CPU-facing end of the bridge
// decodes the access code, forwards accepted requests and tracks FIFO credits
module mmioRequester
    import busPkg::*;
    import mmioPkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_i,
    input  wire accessKind_e rwi_i,
    input  wire addr_t       addr_i,
    input  wire data_t       wdata_i,
    output logic             busy_o,
    reqCreditIf.sender       reqLink
);

    logic    isRead;
    logic    isWrite;
    logic    accept;
    credit_t credits;

    // read/write/idle decode with 11 taken as idle
    always_comb begin
        if (rwi_i == ACC_READ) begin
            isRead  = 1'b1;
            isWrite = 1'b0;
        end else if (rwi_i == ACC_WRITE) begin
            isRead  = 1'b0;
            isWrite = 1'b1;
        end else begin
            isRead  = 1'b0;
            isWrite = 1'b0;
        end
    end

    // busy while no slot is left downstream
    assign busy_o = (credits == '0);

    // a request is taken only while a credit is held
    assign accept = (isRead || isWrite) && !busy_o;

    // credit count and link valid
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reqLink.valid <= 1'b0;
            credits       <= CREDIT_MAX;
        end else begin
            reqLink.valid <= accept;
            // spend one on accept and regain one per returned pulse
            credits <= credits - credit_t'(accept) + credit_t'(reqLink.credit);
        end
    end

    // request payload follows valid by design
    always_ff @(posedge clk) begin
        if (accept) begin
            reqLink.addr  <= addr_i;
            reqLink.wdata <= wdata_i;
            reqLink.write <= isWrite;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reqFifo.sv
`timescale 1ns/1ps
`default_nettype none

// in-order request buffer between the requester and the bus manager
// upstream credits come back one cycle after an entry leaves
module reqFifo
    import busPkg::*;
    import mmioPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst_i,
    reqCreditIf.receiver reqLink,
    reqCreditIf.sender   issueLink
);

    // entry storage, no reset needed
    addr_t    memAddr  [FIFO_DEPTH];
    data_t    memWdata [FIFO_DEPTH];
    logic     memWrite [FIFO_DEPTH];

    fifoPtr_t head;
    fifoPtr_t tail;
    credit_t  count;
    // credits granted by the manager and not yet spent
    credit_t  dnCredits;
    logic     push;
    logic     pop;

    function automatic fifoPtr_t nextPtr(input fifoPtr_t ptr);
        if (ptr == fifoPtr_t'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + fifoPtr_t'(1);
    endfunction

    // the requester never sends without a credit, so a push always fits
    assign push = reqLink.valid;

    // issue the head whenever there is something to send and a credit to spend
    assign pop = (dnCredits != '0) && (count != '0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            head            <= '0;
            tail            <= '0;
            count           <= '0;
            dnCredits       <= '0;
            issueLink.valid <= 1'b0;
            reqLink.credit  <= 1'b0;
        end else begin
            if (push) begin
                tail <= nextPtr(tail);
            end
            if (pop) begin
                head <= nextPtr(head);
            end
            count     <= count + credit_t'(push) - credit_t'(pop);
            dnCredits <= dnCredits + credit_t'(issueLink.credit) - credit_t'(pop);
            issueLink.valid <= pop;
            // slot freed last cycle goes back upstream now
            reqLink.credit  <= issueLink.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            memAddr[tail]  <= reqLink.addr;
            memWdata[tail] <= reqLink.wdata;
            memWrite[tail] <= reqLink.write;
        end
        if (pop) begin
            issueLink.addr  <= memAddr[head];
            issueLink.wdata <= memWdata[head];
            issueLink.write <= memWrite[head];
        end
    end

endmodule

`default_nettype wire

// File: verilog/wishboneManager.sv
`timescale 1ns/1ps
`default_nettype none

// bus manager, one bus cycle per issued request
// grants a single issue credit from IDLE so at most one request is in hand
module wishboneManager
    import busPkg::*;
    import mmioPkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst_i,
    reqCreditIf.receiver issueLink,
    output logic         cyc_o,
    output logic         stb_o,
    output logic         we_o,
    output addr_t        adr_o,
    output data_t        dat_o,
    input  wire logic    ack_i,
    input  wire logic    err_i,
    input  wire data_t   dat_i,
    output data_t        rdata_o,
    output logic         rdataValid_o,
    output logic         accessErr_o
);

    mgrState_e state;
    // set once the idle credit has gone out
    logic      granted;
    logic      arrive;
    logic      done;

    assign arrive = (state == MGR_IDLE) && issueLink.valid;
    assign done   = (state == MGR_BUS) && (ack_i || err_i);

    // one pulse on entry to idle
    assign issueLink.credit = (state == MGR_IDLE) && !granted;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state        <= MGR_IDLE;
            granted      <= 1'b0;
            cyc_o        <= 1'b0;
            stb_o        <= 1'b0;
            we_o         <= 1'b0;
            rdataValid_o <= 1'b0;
            accessErr_o  <= 1'b0;
        end else begin
            rdataValid_o <= 1'b0;
            accessErr_o  <= 1'b0;
            case (state)
                MGR_IDLE: begin
                    if (!granted) begin
                        granted <= 1'b1;
                    end
                    if (arrive) begin
                        cyc_o   <= 1'b1;
                        stb_o   <= 1'b1;
                        we_o    <= issueLink.write;
                        granted <= 1'b0;
                        state   <= MGR_BUS;
                    end
                end
                MGR_BUS: begin
                    // drop the strobe right after the target answers
                    if (done) begin
                        cyc_o        <= 1'b0;
                        stb_o        <= 1'b0;
                        rdataValid_o <= !we_o;
                        accessErr_o  <= err_i;
                        state        <= MGR_RESP;
                    end
                end
                default: begin
                    state <= MGR_IDLE;
                end
            endcase
        end
    end

    // bus payload and returned read word
    always_ff @(posedge clk) begin
        if (arrive) begin
            adr_o <= issueLink.addr;
            dat_o <= issueLink.wdata;
        end
        if (done) begin
            rdata_o <= err_i ? '0 : dat_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/sramWbTarget.sv
`timescale 1ns/1ps
`default_nettype none

// single-port SRAM on the bus
// answers ack or err for one cycle, one cycle after the strobe appears
module sramWbTarget
    import busPkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_i,
    input  wire logic  cyc_i,
    input  wire logic  stb_i,
    input  wire logic  we_i,
    input  wire addr_t adr_i,
    input  wire data_t dat_i,
    output logic       ack_o,
    output logic       err_o,
    output data_t      dat_o
);

    data_t    mem [SRAM_WORDS];
    sramIdx_t idx;
    logic     inRange;
    logic     start;

    assign idx     = adr_i[SRAM_AW-1:0];
    assign inRange = (adr_i <= SRAM_LAST);

    // first cycle of a strobe, the answer has not gone out yet
    assign start = cyc_i && stb_i && !ack_o && !err_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
        end else begin
            ack_o <= start && inRange;
            err_o <= start && !inRange;
        end
    end

    // array access, contents survive reset
    always_ff @(posedge clk) begin
        if (start) begin
            if (inRange && we_i) begin
                mem[idx] <= dat_i;
            end
            if (inRange && !we_i) begin
                dat_o <= mem[idx];
            end else begin
                dat_o <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/memSubsystemTop.sv
`timescale 1ns/1ps
`default_nettype none

// memory side of the processor system
// requester -> request FIFO -> bus manager -> SRAM
module memSubsystemTop
    import busPkg::*;
    import mmioPkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst_i,
    input  wire accessKind_e rwi_i,
    input  wire addr_t       addr_i,
    input  wire data_t       wdata_i,
    output logic             busy_o,
    output data_t            rdata_o,
    output logic             rdataValid_o,
    output logic             accessErr_o
);

    // bus between manager and SRAM
    logic  wbCyc;
    logic  wbStb;
    logic  wbWe;
    addr_t wbAdr;
    data_t wbDatToSram;
    logic  wbAck;
    logic  wbErr;
    data_t wbDatToMgr;

    reqCreditIf reqLink ();
    reqCreditIf issueLink ();

    mmioRequester u_mmioRequester (
        .clk(clk), .rst_i(rst_i), .rwi_i(rwi_i), .addr_i(addr_i),
        .wdata_i(wdata_i), .busy_o(busy_o), .reqLink(reqLink.sender)
    );

    reqFifo u_reqFifo (
        .clk(clk), .rst_i(rst_i),
        .reqLink(reqLink.receiver), .issueLink(issueLink.sender)
    );

    wishboneManager u_wishboneManager (
        .clk(clk), .rst_i(rst_i), .issueLink(issueLink.receiver),
        .cyc_o(wbCyc), .stb_o(wbStb), .we_o(wbWe), .adr_o(wbAdr), .dat_o(wbDatToSram),
        .ack_i(wbAck), .err_i(wbErr), .dat_i(wbDatToMgr),
        .rdata_o(rdata_o), .rdataValid_o(rdataValid_o), .accessErr_o(accessErr_o)
    );

    sramWbTarget u_sramWbTarget (
        .clk(clk), .rst_i(rst_i), .cyc_i(wbCyc), .stb_i(wbStb), .we_i(wbWe),
        .adr_i(wbAdr), .dat_i(wbDatToSram),
        .ack_o(wbAck), .err_o(wbErr), .dat_o(wbDatToMgr)
    );

endmodule

`default_nettype wire

// File: tests/memSubsystemChecks.svh
// response and protocol checks, included inside memSubsystemTb
// all concurrent checks sample mid-cycle where DUT outputs and driven inputs are settled

// any response pulse needs a request still waiting in the model
respExpected: assert property (@(negedge clk) disable iff (rst_i)
    (rdataValid_o || accessErr_o) |-> headValid)
else begin
    errCount++;
    $display("response pulse at %0t with no request outstanding", $time);
end

// reads pulse rdataValid_o, erroneous writes only pulse accessErr_o
kindMatch: assert property (@(negedge clk) disable iff (rst_i)
    ((rdataValid_o || accessErr_o) && headValid) |-> (rdataValid_o == headRead))
else begin
    errCount++;
    $display("Fail rdataValid_o expected %h got %h", headRead, rdataValid_o);
end

dataMatch: assert property (@(negedge clk) disable iff (rst_i)
    (rdataValid_o && headValid) |-> (rdata_o == headData))
else begin
    errCount++;
    $display("Fail rdata_o expected %h got %h", headData, rdata_o);
end

errMatch: assert property (@(negedge clk) disable iff (rst_i)
    ((rdataValid_o || accessErr_o) && headValid) |-> (accessErr_o == headErr))
else begin
    errCount++;
    $display("Fail accessErr_o expected %h got %h", headErr, accessErr_o);
end

knownOutputs: assert property (@(negedge clk) disable iff (rst_i)
    !$isunknown({busy_o, rdataValid_o, accessErr_o}))
else begin
    errCount++;
    $display("busy_o, rdataValid_o or accessErr_o went unknown at %0t", $time);
end

// the CPU side must hold idle while the requester is out of credits
noRequestWhileBusy: assert property (@(negedge clk) disable iff (rst_i)
    busy_o |-> (rwi_i != ACC_READ && rwi_i != ACC_WRITE))
else begin
    errCount++;
    $display("a request was presented while busy_o was high at %0t", $time);
end

// outputs stay quiet for a number of idle cycles
task automatic checkQuiet(input int cycles);
    repeat (cycles) begin
        @(negedge clk);
        assert (busy_o == 1'b0) else begin
            errCount++;
            $display("Fail busy_o expected %h got %h", 1'b0, busy_o);
        end
        assert (rdataValid_o == 1'b0) else begin
            errCount++;
            $display("Fail rdataValid_o expected %h got %h", 1'b0, rdataValid_o);
        end
        assert (accessErr_o == 1'b0) else begin
            errCount++;
            $display("Fail accessErr_o expected %h got %h", 1'b0, accessErr_o);
        end
    end
    @(posedge clk);
    #DRIVE_DLY;
endtask

task automatic checkBusySeen();
    assert (busySeen) else begin
        errCount++;
        $display("busy_o never rose while the burst filled the FIFO");
    end
endtask

task automatic checkCount(input string what, input int actual, input int expected);
    assert (actual == expected) else begin
        errCount++;
        $display("%s: expected %0d responses but saw %0d", what, expected, actual);
    end
endtask

// File: tests/memSubsystemTb.sv
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb
    import busPkg::*;
    import mmioPkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_REQS  = 200;
    // directed requests of tests 2 to 4 plus the random ones
    localparam int TOTAL_REQS     = 2 + 16 + 6 + RANDOM_REQS;
    localparam int TIMEOUT_CYCLES = TOTAL_REQS * (FIFO_DEPTH + 6) + 200;

    logic        clk;
    logic        rst_i;
    accessKind_e rwi_i;
    addr_t       addr_i;
    data_t       wdata_i;
    logic        busy_o;
    data_t       rdata_o;
    logic        rdataValid_o;
    logic        accessErr_o;

    // reference model: written words and expected responses {read, err, data}
    data_t             model [addr_t];
    logic [DATA_W+1:0] expQ [$];
    logic              headValid;
    logic              headRead;
    logic              headErr;
    data_t             headData;

    int     pushedCount;
    int     seenCount;
    int     errCount;
    int     testsPassed;
    int     testsFailed;
    int     errsBefore;
    int     seenBefore;
    logic   busySeen;
    integer seed;

    memSubsystemTop u_memSubsystemTop (
        .clk(clk), .rst_i(rst_i), .rwi_i(rwi_i), .addr_i(addr_i), .wdata_i(wdata_i),
        .busy_o(busy_o), .rdata_o(rdata_o), .rdataValid_o(rdataValid_o),
        .accessErr_o(accessErr_o)
    );

    `include "memSubsystemChecks.svh"

    task automatic refreshHead();
        headValid = (expQ.size() != 0);
        if (headValid) begin
            {headRead, headErr, headData} = expQ[0];
        end
    endtask

    task automatic pushResp(input logic isRead, input logic isErr, input data_t data);
        expQ.push_back({isRead, isErr, data});
        pushedCount++;
        refreshHead();
    endtask

    // in-range writes update the model and show nothing at the outputs
    task automatic recordRequest(input accessKind_e kind, input addr_t addr, input data_t data);
        if (kind == ACC_WRITE && addr < addr_t'(SRAM_WORDS)) begin
            model[addr] = data;
        end else if (kind == ACC_WRITE) begin
            pushResp(1'b0, 1'b1, '0);
        end else if (kind == ACC_READ && addr < addr_t'(SRAM_WORDS)) begin
            pushResp(1'b1, 1'b0, model.exists(addr) ? model[addr] : '0);
        end else if (kind == ACC_READ) begin
            pushResp(1'b1, 1'b1, '0);
        end
    endtask

    // called and returns just after a rising edge
    task automatic sendRequest(input accessKind_e kind, input addr_t addr, input data_t data);
        while (busy_o) begin
            rwi_i = ACC_IDLE;
            @(posedge clk);
            #DRIVE_DLY;
        end
        rwi_i   = kind;
        addr_i  = addr;
        wdata_i = data;
        recordRequest(kind, addr, data);
        @(posedge clk);
        #DRIVE_DLY;
        rwi_i = ACC_IDLE;
    endtask

    task automatic waitDrain();
        while (expQ.size() != 0) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    // mostly reads and writes in 0..63, one in eight addresses past the SRAM
    task automatic runRandom();
        int          r;
        accessKind_e kind;
        addr_t       addr;
        data_t       data;
        for (int i = 0; i < RANDOM_REQS; i++) begin
            r    = $random(seed);
            data = $random(seed);
            case (r[2:0])
                3'd0: kind = ACC_IDLE;
                3'd1, 3'd2, 3'd3: kind = ACC_WRITE;
                default: kind = ACC_READ;
            endcase
            if (r[6:4] == 3'd0) begin
                addr = addr_t'(SRAM_WORDS) + addr_t'(r[19:8]);
            end else begin
                addr = addr_t'(r[13:8]);
            end
            // SRAM contents are undefined until written
            if (kind == ACC_READ && addr < addr_t'(SRAM_WORDS) && !model.exists(addr)) begin
                kind = ACC_WRITE;
            end
            sendRequest(kind, addr, data);
        end
    endtask

    task automatic finishTest(input string name);
        if (errCount == errsBefore) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: %0d errors", name, errCount - errsBefore);
        end
        errsBefore = errCount;
    endtask

    // retire the head entry on each response pulse
    always @(posedge clk) begin
        if (!rst_i) begin
            if (busy_o) begin
                busySeen = 1'b1;
            end
            if (rdataValid_o || accessErr_o) begin
                seenCount++;
                if (expQ.size() != 0) begin
                    void'(expQ.pop_front());
                end
                refreshHead();
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles with responses still missing", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        seed        = 20182;
        rst_i       = 1'b1;
        rwi_i       = ACC_IDLE;
        addr_i      = '0;
        wdata_i     = '0;
        headValid   = 1'b0;
        headRead    = 1'b0;
        headErr     = 1'b0;
        headData    = '0;
        pushedCount = 0;
        seenCount   = 0;
        errCount    = 0;
        testsPassed = 0;
        testsFailed = 0;
        errsBefore  = 0;
        busySeen    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_i = 1'b0;

        checkQuiet(10);
        finishTest("1 reset and idle");

        sendRequest(ACC_WRITE, 32'd10, 32'hDEAD_BEEF);
        sendRequest(ACC_READ, 32'd10, '0);
        waitDrain();
        finishTest("2 write then read");

        busySeen   = 1'b0;
        seenBefore = seenCount;
        for (int i = 0; i < 8; i++) begin
            sendRequest(ACC_WRITE, addr_t'(32 + i), 32'h5A00_0000 | (i * 32'h0001_0101));
        end
        for (int i = 0; i < 8; i++) begin
            sendRequest(ACC_READ, addr_t'(32 + i), '0);
        end
        waitDrain();
        checkBusySeen();
        checkCount("burst reads", seenCount - seenBefore, 8);
        finishTest("3 back-to-back burst");

        // 259 aliases word 3 in the low index bits
        seenBefore = seenCount;
        sendRequest(ACC_WRITE, 32'd3, 32'h1234_5678);
        sendRequest(ACC_WRITE, 32'd259, 32'hBAD0_0BAD);
        sendRequest(ACC_READ, 32'd256, '0);
        sendRequest(ACC_READ, 32'hFFFF_FFF0, '0);
        sendRequest(ACC_WRITE, 32'h8000_0000, 32'hFFFF_FFFF);
        sendRequest(ACC_READ, 32'd3, '0);
        waitDrain();
        checkCount("out-of-range accesses", seenCount - seenBefore, 5);
        finishTest("4 out-of-range addresses");

        runRandom();
        waitDrain();
        checkCount("all accepted requests", seenCount, pushedCount);
        finishTest("5 random traffic");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 testsPassed, testsFailed, errCount);
        if (errCount == 0 && testsFailed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+tests
verilog/busPkg.sv
verilog/mmioPkg.sv
verilog/reqCreditIf.sv
verilog/mmioRequester.sv
verilog/reqFifo.sv
verilog/wishboneManager.sv
verilog/sramWbTarget.sv
verilog/memSubsystemTop.sv
tests/memSubsystemTb.sv
